//--- rtl/wavegen_axi_pkg.sv
package wavegen_axi_pkg;

    ////////////////////
    // AXI4-Lite bus sizes
    ////////////////////

    // data bus is one 32-bit register word
    localparam int data_width = 32;
    // one strobe per data byte
    localparam int strb_width = data_width / 8;

    // register index sits in address bits 5:2
    localparam int reg_index_width = 4;

    ////////////////////
    // response codes
    ////////////////////

    // slave never signals SLVERR or DECERR
    localparam logic [1:0] resp_okay = 2'b00;

endpackage

//--- rtl/wavegen_axi_read.sv
module wavegen_axi_read #(
    parameter int addr_width = 6
) (
    input  logic                                        axi_clk,
    input  logic                                        axi_resetn,
    input  logic [addr_width-1:0]                       axi_araddr,
    input  logic                                        axi_arvalid,
    input  logic                                        axi_rready,
    input  logic [wavegen_axi_pkg::data_width-1:0]      rd_word,
    output logic                                        axi_arready,
    output logic [wavegen_axi_pkg::data_width-1:0]      axi_rdata,
    output logic [1:0]                                  axi_rresp,
    output logic                                        axi_rvalid,
    output logic [wavegen_axi_pkg::reg_index_width-1:0] rd_index
);

    logic accept;

    // take a new address only when idle and no data is outstanding
    assign accept = axi_arvalid && !axi_arready && !axi_rvalid;

    ////////////////////
    // address channel
    ////////////////////

    always_ff @(posedge axi_clk) begin
        if (!axi_resetn) begin
            axi_arready <= 1'b0;
        end else begin
            // one-cycle pulse
            axi_arready <= accept;
        end
    end

    always_ff @(posedge axi_clk) begin
        if (accept) begin
            rd_index <= axi_araddr[2 +: wavegen_axi_pkg::reg_index_width];
        end
    end

    ////////////////////
    // data channel
    ////////////////////

    // register select is settled in the arready cycle
    always_ff @(posedge axi_clk) begin
        if (axi_arready) begin
            axi_rdata <= rd_word;
        end
    end

    always_ff @(posedge axi_clk) begin
        if (!axi_resetn) begin
            axi_rvalid <= 1'b0;
        end else if (axi_arready) begin
            axi_rvalid <= 1'b1;
        end else if (axi_rready) begin
            axi_rvalid <= 1'b0;
        end
    end

    assign axi_rresp = wavegen_axi_pkg::resp_okay;

    // data must not move under a stalled master
    rdata_stable_a : assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        axi_rvalid && !axi_rready |=> $stable(axi_rdata));

endmodule

//--- rtl/wavegen_axi_write.sv
module wavegen_axi_write #(
    parameter int addr_width = 6
) (
    input  logic                                        axi_clk,
    input  logic                                        axi_resetn,
    input  logic [addr_width-1:0]                       axi_awaddr,
    input  logic                                        axi_awvalid,
    input  logic [wavegen_axi_pkg::data_width-1:0]      axi_wdata,
    input  logic [wavegen_axi_pkg::strb_width-1:0]      axi_wstrb,
    input  logic                                        axi_wvalid,
    input  logic                                        axi_bready,
    output logic                                        axi_awready,
    output logic                                        axi_wready,
    output logic                                        axi_bvalid,
    output logic [1:0]                                  axi_bresp,
    output logic                                        wr_en,
    output logic [wavegen_axi_pkg::reg_index_width-1:0] wr_index,
    output logic [wavegen_axi_pkg::data_width-1:0]      wr_data,
    output logic [wavegen_axi_pkg::strb_width-1:0]      wr_strb
);

    // high while the slave may take a new write
    logic aw_en;
    // one-cycle acceptance pulse, shared by both ready lines
    logic accept_q;
    logic accept;

    // address and data must both be present, and no response pending
    assign accept = axi_awvalid && axi_wvalid && !accept_q && aw_en;

    ////////////////////
    // handshake
    ////////////////////

    always_ff @(posedge axi_clk) begin
        if (!axi_resetn) begin
            accept_q <= 1'b0;
            aw_en    <= 1'b1;
        end else begin
            accept_q <= accept;
            if (accept) begin
                aw_en <= 1'b0;
            end else if (axi_bvalid && axi_bready) begin
                // response taken, reopen for the next write
                aw_en <= 1'b1;
            end
        end
    end

    assign axi_awready = accept_q;
    assign axi_wready  = accept_q;
    // register file updates in the ready cycle
    assign wr_en       = accept_q;

    // capture index, data and strobes with the address
    always_ff @(posedge axi_clk) begin
        if (accept) begin
            wr_index <= axi_awaddr[2 +: wavegen_axi_pkg::reg_index_width];
            wr_data  <= axi_wdata;
            wr_strb  <= axi_wstrb;
        end
    end

    ////////////////////
    // write response
    ////////////////////

    always_ff @(posedge axi_clk) begin
        if (!axi_resetn) begin
            axi_bvalid <= 1'b0;
        end else if (accept_q) begin
            axi_bvalid <= 1'b1;
        end else if (axi_bready) begin
            axi_bvalid <= 1'b0;
        end
    end

    assign axi_bresp = wavegen_axi_pkg::resp_okay;

    // response is held until the master takes it
    bvalid_hold_a : assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        axi_bvalid && !axi_bready |=> axi_bvalid);

    // no second write is accepted behind a pending response
    no_aw_while_b_a : assert property (@(posedge axi_clk) disable iff (!axi_resetn)
        axi_bvalid |=> !$rose(axi_awready));

endmodule

//--- rtl/wavegen_reg_pkg.sv
package wavegen_reg_pkg;

    ////////////////////
    // register indices
    ////////////////////

    // byte offset is index * 4
    localparam logic [3:0] mode_reg      = 4'd0;
    localparam logic [3:0] run_reg       = 4'd1;
    localparam logic [3:0] freq_a_reg    = 4'd2;
    localparam logic [3:0] freq_b_reg    = 4'd3;
    localparam logic [3:0] offset_reg    = 4'd4;
    localparam logic [3:0] ampltd_reg    = 4'd5;
    localparam logic [3:0] dtcyc_reg     = 4'd6;
    localparam logic [3:0] cycles_reg    = 4'd7;
    localparam logic [3:0] phase_off_reg = 4'd8;
    localparam logic [3:0] arb_depth_reg = 4'd9;

    ////////////////////
    // field widths
    ////////////////////

    // waveform select per channel
    localparam int mode_width = 3;
    // per-channel halves and wave samples
    localparam int half_width = 16;
    // amplitude is a Q1.15 gain
    localparam int scale_shift = 15;

    // both channels run out of reset
    localparam logic enable_reset = 1'b1;

    ////////////////////
    // register word
    ////////////////////

    // hi half feeds channel b, lo half feeds channel a
    typedef struct packed {
        logic [half_width-1:0] hi;
        logic [half_width-1:0] lo;
    } reg_halves_t;

    // word view for freq and arb_depth, half view for split registers
    typedef union packed {
        logic [2*half_width-1:0] word;
        reg_halves_t             half;
    } reg_word_u;

endpackage

//--- rtl/wavegen_regs.sv
module wavegen_regs (
    input  logic                                        axi_clk,
    input  logic                                        axi_resetn,
    input  logic                                        wr_en,
    input  logic [wavegen_axi_pkg::reg_index_width-1:0] wr_index,
    input  logic [wavegen_axi_pkg::data_width-1:0]      wr_data,
    input  logic [wavegen_axi_pkg::strb_width-1:0]      wr_strb,
    input  logic [wavegen_axi_pkg::reg_index_width-1:0] rd_index,
    output logic [wavegen_axi_pkg::data_width-1:0]      rd_word,
    output logic [wavegen_reg_pkg::mode_width-1:0]      mode_a,
    output logic [wavegen_reg_pkg::mode_width-1:0]      mode_b,
    output logic                                        enable_a,
    output logic                                        enable_b,
    output logic [wavegen_axi_pkg::data_width-1:0]      freq_a,
    output logic [wavegen_axi_pkg::data_width-1:0]      freq_b,
    output logic [wavegen_reg_pkg::half_width-1:0]      dtcyc_a,
    output logic [wavegen_reg_pkg::half_width-1:0]      dtcyc_b,
    output logic [wavegen_reg_pkg::half_width-1:0]      cycles_a,
    output logic [wavegen_reg_pkg::half_width-1:0]      cycles_b,
    output logic [wavegen_reg_pkg::half_width-1:0]      phase_off_a,
    output logic [wavegen_reg_pkg::half_width-1:0]      phase_off_b,
    output logic [wavegen_axi_pkg::data_width-1:0]      arb_depth,
    output logic [wavegen_reg_pkg::half_width-1:0]      amp_a,
    output logic [wavegen_reg_pkg::half_width-1:0]      amp_b,
    output logic [wavegen_reg_pkg::half_width-1:0]      offset_a,
    output logic [wavegen_reg_pkg::half_width-1:0]      offset_b
);

    // full-word registers
    wavegen_reg_pkg::reg_word_u freq_a_q, freq_b_q, arb_depth_q;
    // split registers, lo half is channel a
    wavegen_reg_pkg::reg_word_u offset_q, ampltd_q, dtcyc_q, cycles_q, phase_off_q;

    // replace only the bytes whose strobe is set
    function automatic logic [wavegen_axi_pkg::data_width-1:0] merge_bytes(
        input logic [wavegen_axi_pkg::data_width-1:0] old_word,
        input logic [wavegen_axi_pkg::data_width-1:0] new_word,
        input logic [wavegen_axi_pkg::strb_width-1:0] strb
    );
        logic [wavegen_axi_pkg::data_width-1:0] res;
        res = old_word;
        for (int i = 0; i < wavegen_axi_pkg::strb_width; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return res;
    endfunction

    ////////////////////
    // write decode
    ////////////////////

    always_ff @(posedge axi_clk) begin
        if (!axi_resetn) begin
            mode_a      <= '0;
            mode_b      <= '0;
            enable_a    <= wavegen_reg_pkg::enable_reset;
            enable_b    <= wavegen_reg_pkg::enable_reset;
            freq_a_q    <= '0;
            freq_b_q    <= '0;
            offset_q    <= '0;
            ampltd_q    <= '0;
            dtcyc_q     <= '0;
            cycles_q    <= '0;
            phase_off_q <= '0;
            arb_depth_q <= '0;
        end else if (wr_en) begin
            case (wr_index)
                // mode and run live in byte 0 only
                wavegen_reg_pkg::mode_reg: begin
                    if (wr_strb[0]) begin
                        {mode_b, mode_a} <= wr_data[2*wavegen_reg_pkg::mode_width-1:0];
                    end
                end
                wavegen_reg_pkg::run_reg: begin
                    if (wr_strb[0]) begin
                        {enable_b, enable_a} <= wr_data[1:0];
                    end
                end
                wavegen_reg_pkg::freq_a_reg:
                    freq_a_q.word <= merge_bytes(freq_a_q.word, wr_data, wr_strb);
                wavegen_reg_pkg::freq_b_reg:
                    freq_b_q.word <= merge_bytes(freq_b_q.word, wr_data, wr_strb);
                // strobes 1:0 hit channel a, 3:2 hit channel b
                wavegen_reg_pkg::offset_reg:
                    offset_q.word <= merge_bytes(offset_q.word, wr_data, wr_strb);
                wavegen_reg_pkg::ampltd_reg:
                    ampltd_q.word <= merge_bytes(ampltd_q.word, wr_data, wr_strb);
                wavegen_reg_pkg::dtcyc_reg:
                    dtcyc_q.word <= merge_bytes(dtcyc_q.word, wr_data, wr_strb);
                wavegen_reg_pkg::cycles_reg:
                    cycles_q.word <= merge_bytes(cycles_q.word, wr_data, wr_strb);
                wavegen_reg_pkg::phase_off_reg:
                    phase_off_q.word <= merge_bytes(phase_off_q.word, wr_data, wr_strb);
                wavegen_reg_pkg::arb_depth_reg:
                    arb_depth_q.word <= merge_bytes(arb_depth_q.word, wr_data, wr_strb);
                // indices 10 to 15 are not mapped
                default: ;
            endcase
        end
    end

    ////////////////////
    // field outputs
    ////////////////////

    assign freq_a      = freq_a_q.word;
    assign freq_b      = freq_b_q.word;
    assign arb_depth   = arb_depth_q.word;
    assign offset_a    = offset_q.half.lo;
    assign offset_b    = offset_q.half.hi;
    assign amp_a       = ampltd_q.half.lo;
    assign amp_b       = ampltd_q.half.hi;
    assign dtcyc_a     = dtcyc_q.half.lo;
    assign dtcyc_b     = dtcyc_q.half.hi;
    assign cycles_a    = cycles_q.half.lo;
    assign cycles_b    = cycles_q.half.hi;
    assign phase_off_a = phase_off_q.half.lo;
    assign phase_off_b = phase_off_q.half.hi;

    ////////////////////
    // read select
    ////////////////////

    // unused bits and unmapped indices read as zero
    always_comb begin
        rd_word = '0;
        case (rd_index)
            wavegen_reg_pkg::mode_reg:
                rd_word[2*wavegen_reg_pkg::mode_width-1:0] = {mode_b, mode_a};
            wavegen_reg_pkg::run_reg:       rd_word[1:0] = {enable_b, enable_a};
            wavegen_reg_pkg::freq_a_reg:    rd_word = freq_a_q.word;
            wavegen_reg_pkg::freq_b_reg:    rd_word = freq_b_q.word;
            wavegen_reg_pkg::offset_reg:    rd_word = offset_q.word;
            wavegen_reg_pkg::ampltd_reg:    rd_word = ampltd_q.word;
            wavegen_reg_pkg::dtcyc_reg:     rd_word = dtcyc_q.word;
            wavegen_reg_pkg::cycles_reg:    rd_word = cycles_q.word;
            wavegen_reg_pkg::phase_off_reg: rd_word = phase_off_q.word;
            wavegen_reg_pkg::arb_depth_reg: rd_word = arb_depth_q.word;
            default:                        rd_word = '0;
        endcase
    end

endmodule

//--- rtl/wavegen_scale.sv
module wavegen_scale (
    input  logic                                        axi_clk,
    input  logic                                        axi_resetn,
    input  logic signed [wavegen_reg_pkg::half_width-1:0] sample,
    input  logic [wavegen_reg_pkg::half_width-1:0]      amp,
    input  logic [wavegen_reg_pkg::half_width-1:0]      offset,
    input  logic                                        enable,
    output logic [wavegen_reg_pkg::half_width-1:0]      scaled
);

    logic signed [2*wavegen_reg_pkg::half_width-1:0] product;
    logic signed [2*wavegen_reg_pkg::half_width-1:0] shifted;
    logic [wavegen_reg_pkg::half_width-1:0]          sum;

    // amplitude is a signed Q1.15 gain
    assign product = $signed(amp) * sample;
    assign shifted = product >>> wavegen_reg_pkg::scale_shift;
    // keep the low half, offset wraps modulo 2^16
    assign sum     = shifted[wavegen_reg_pkg::half_width-1:0] + offset;

    // one cycle of latency, disabled channel sits at zero
    always_ff @(posedge axi_clk) begin
        if (!axi_resetn) begin
            scaled <= '0;
        end else begin
            scaled <= enable ? sum : '0;
        end
    end

endmodule

//--- rtl/wavegen_top.sv
module wavegen_top #(
    parameter int addr_width = 6
) (
    input  logic                                          axi_clk,
    input  logic                                          axi_resetn,
    // write address and data
    input  logic [addr_width-1:0]                         axi_awaddr,
    input  logic                                          axi_awvalid,
    output logic                                          axi_awready,
    input  logic [wavegen_axi_pkg::data_width-1:0]        axi_wdata,
    input  logic [wavegen_axi_pkg::strb_width-1:0]        axi_wstrb,
    input  logic                                          axi_wvalid,
    output logic                                          axi_wready,
    // write response
    output logic [1:0]                                    axi_bresp,
    output logic                                          axi_bvalid,
    input  logic                                          axi_bready,
    // read address and data
    input  logic [addr_width-1:0]                         axi_araddr,
    input  logic                                          axi_arvalid,
    output logic                                          axi_arready,
    output logic [wavegen_axi_pkg::data_width-1:0]        axi_rdata,
    output logic [1:0]                                    axi_rresp,
    output logic                                          axi_rvalid,
    input  logic                                          axi_rready,
    // samples from the waveform core
    input  logic signed [wavegen_reg_pkg::half_width-1:0] wave_a,
    input  logic signed [wavegen_reg_pkg::half_width-1:0] wave_b,
    output logic [wavegen_reg_pkg::half_width-1:0]        out_a,
    output logic [wavegen_reg_pkg::half_width-1:0]        out_b,
    // configuration to the waveform core
    output logic [wavegen_reg_pkg::mode_width-1:0]        mode_a,
    output logic [wavegen_reg_pkg::mode_width-1:0]        mode_b,
    output logic                                          enable_a,
    output logic                                          enable_b,
    output logic [wavegen_axi_pkg::data_width-1:0]        freq_a,
    output logic [wavegen_axi_pkg::data_width-1:0]        freq_b,
    output logic [wavegen_reg_pkg::half_width-1:0]        dtcyc_a,
    output logic [wavegen_reg_pkg::half_width-1:0]        dtcyc_b,
    output logic [wavegen_reg_pkg::half_width-1:0]        cycles_a,
    output logic [wavegen_reg_pkg::half_width-1:0]        cycles_b,
    output logic [wavegen_reg_pkg::half_width-1:0]        phase_off_a,
    output logic [wavegen_reg_pkg::half_width-1:0]        phase_off_b,
    output logic [wavegen_axi_pkg::data_width-1:0]        arb_depth
);

    logic                                        wr_en;
    logic [wavegen_axi_pkg::reg_index_width-1:0] wr_index;
    logic [wavegen_axi_pkg::data_width-1:0]      wr_data;
    logic [wavegen_axi_pkg::strb_width-1:0]      wr_strb;
    logic [wavegen_axi_pkg::reg_index_width-1:0] rd_index;
    logic [wavegen_axi_pkg::data_width-1:0]      rd_word;
    logic [wavegen_reg_pkg::half_width-1:0]      amp_a, amp_b;
    logic [wavegen_reg_pkg::half_width-1:0]      offset_a, offset_b;

    ////////////////////
    // bus channels
    ////////////////////

    wavegen_axi_write #(.addr_width(addr_width)) u_write (
        .axi_clk, .axi_resetn, .axi_awaddr, .axi_awvalid, .axi_wdata, .axi_wstrb,
        .axi_wvalid, .axi_bready, .axi_awready, .axi_wready, .axi_bvalid, .axi_bresp,
        .wr_en, .wr_index, .wr_data, .wr_strb
    );

    wavegen_axi_read #(.addr_width(addr_width)) u_read (
        .axi_clk, .axi_resetn, .axi_araddr, .axi_arvalid, .axi_rready, .rd_word,
        .axi_arready, .axi_rdata, .axi_rresp, .axi_rvalid, .rd_index
    );

    ////////////////////
    // registers and output stage
    ////////////////////

    wavegen_regs u_regs (
        .axi_clk, .axi_resetn, .wr_en, .wr_index, .wr_data, .wr_strb, .rd_index,
        .rd_word, .mode_a, .mode_b, .enable_a, .enable_b, .freq_a, .freq_b,
        .dtcyc_a, .dtcyc_b, .cycles_a, .cycles_b, .phase_off_a, .phase_off_b,
        .arb_depth, .amp_a, .amp_b, .offset_a, .offset_b
    );

    // channel a
    wavegen_scale u_scale_a (
        .axi_clk, .axi_resetn, .sample(wave_a), .amp(amp_a), .offset(offset_a),
        .enable(enable_a), .scaled(out_a)
    );

    // channel b
    wavegen_scale u_scale_b (
        .axi_clk, .axi_resetn, .sample(wave_b), .amp(amp_b), .offset(offset_b),
        .enable(enable_b), .scaled(out_b)
    );

endmodule

//--- sim/wavegen_clk_gen.sv
module wavegen_clk_gen (
    output logic axi_clk,
    output logic axi_resetn
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    localparam real half_period = 2.0;
    // cycles with reset held low
    localparam int reset_cycles = 10;

    initial begin
        axi_clk = 1'b0;
        forever begin
            #(half_period) axi_clk = ~axi_clk;
        end
    end

    // released half a ns after an edge, ahead of the testbench sample point
    initial begin
        axi_resetn = 1'b0;
        repeat (reset_cycles) @(posedge axi_clk);
        #0.5;
        axi_resetn = 1'b1;
    end

endmodule

//--- sim/wavegen_tb.sv
module wavegen_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int addr_width     = 6;
    localparam int timeout_cycles = 100;
    localparam int num_writes     = 200;

    logic                    axi_clk;
    logic                    axi_resetn;
    logic [addr_width-1:0]   axi_awaddr;
    logic                    axi_awvalid;
    logic                    axi_awready;
    logic [31:0]             axi_wdata;
    logic [3:0]              axi_wstrb;
    logic                    axi_wvalid;
    logic                    axi_wready;
    logic [1:0]              axi_bresp;
    logic                    axi_bvalid;
    logic                    axi_bready;
    logic [addr_width-1:0]   axi_araddr;
    logic                    axi_arvalid;
    logic                    axi_arready;
    logic [31:0]             axi_rdata;
    logic [1:0]              axi_rresp;
    logic                    axi_rvalid;
    logic                    axi_rready;
    logic signed [15:0]      wave_a;
    logic signed [15:0]      wave_b;
    logic [15:0]             out_a;
    logic [15:0]             out_b;
    logic [2:0]              mode_a;
    logic [2:0]              mode_b;
    logic                    enable_a;
    logic                    enable_b;
    logic [31:0]             freq_a;
    logic [31:0]             freq_b;
    logic [15:0]             dtcyc_a;
    logic [15:0]             dtcyc_b;
    logic [15:0]             cycles_a;
    logic [15:0]             cycles_b;
    logic [15:0]             phase_off_a;
    logic [15:0]             phase_off_b;
    logic [31:0]             arb_depth;

    // shadow of the register map by bus index
    logic [31:0] shadow [16];
    integer      seed;

    wavegen_clk_gen u_clk_gen (.axi_clk, .axi_resetn);

    wavegen_top #(.addr_width(addr_width)) dut (
        .axi_clk, .axi_resetn, .axi_awaddr, .axi_awvalid, .axi_awready, .axi_wdata,
        .axi_wstrb, .axi_wvalid, .axi_wready, .axi_bresp, .axi_bvalid, .axi_bready,
        .axi_araddr, .axi_arvalid, .axi_arready, .axi_rdata, .axi_rresp, .axi_rvalid,
        .axi_rready, .wave_a, .wave_b, .out_a, .out_b, .mode_a, .mode_b, .enable_a,
        .enable_b, .freq_a, .freq_b, .dtcyc_a, .dtcyc_b, .cycles_a, .cycles_b,
        .phase_off_a, .phase_off_b, .arb_depth
    );

    ////////////////////
    // reporting
    ////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("error: %s expected 0x%08h actual 0x%08h",
                                name, expected, actual));
        end
    endtask

    ////////////////////
    // model
    ////////////////////

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // mode and run take byte 0 only
    // indices 10 to 15 are not mapped
    function automatic void apply_write(input logic [3:0] idx, input logic [31:0] data,
                                        input logic [3:0] strb);
        if (idx == wavegen_reg_pkg::mode_reg) begin
            if (strb[0]) begin
                shadow[idx] = {26'd0, data[5:0]};
            end
        end else if (idx == wavegen_reg_pkg::run_reg) begin
            if (strb[0]) begin
                shadow[idx] = {30'd0, data[1:0]};
            end
        end else if (idx <= wavegen_reg_pkg::arb_depth_reg) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    shadow[idx][i*8 +: 8] = data[i*8 +: 8];
                end
            end
        end
    endfunction

    // floor of amp times sample over 2^15 plus offset modulo 2^16
    function automatic logic [15:0] expected_scaled(input logic [15:0] amp,
                                                    input logic [15:0] offset,
                                                    input logic [15:0] sample,
                                                    input logic en);
        int          a_val;
        int          s_val;
        int          prod;
        int          quot;
        logic [15:0] res;
        a_val = $signed(amp);
        s_val = $signed(sample);
        prod  = a_val * s_val;
        quot  = prod / 32768;
        // round toward minus infinity like an arithmetic shift
        if (prod < 0 && prod % 32768 != 0) begin
            quot = quot - 1;
        end
        res = quot[15:0] + offset;
        return en ? res : 16'd0;
    endfunction

    ////////////////////
    // bus tasks
    ////////////////////

    // sample and drive just after the rising edge
    task automatic tick();
        @(posedge axi_clk);
        #1;
    endtask

    task automatic write_start(input logic [3:0] idx, input logic [31:0] data,
                               input logic [3:0] strb);
        axi_awaddr       = '0;
        axi_awaddr[5:2]  = idx;
        axi_wdata        = data;
        axi_wstrb        = strb;
        axi_awvalid      = 1'b1;
        axi_wvalid       = 1'b1;
    endtask

    task automatic wait_write_ready();
        int waited;
        waited = 0;
        do begin
            tick();
            waited++;
            if (waited > timeout_cycles) begin
                abort_run("timeout: write address was never accepted");
            end
        end while (!axi_awready);
        check_value("wready with awready", 1, axi_wready);
        axi_awvalid = 1'b0;
        axi_wvalid  = 1'b0;
    endtask

    task automatic wait_bvalid();
        int waited;
        waited = 0;
        while (!axi_bvalid) begin
            tick();
            waited++;
            if (waited > timeout_cycles) begin
                abort_run("timeout: write response never became valid");
            end
        end
        check_value("bresp", wavegen_axi_pkg::resp_okay, axi_bresp);
    endtask

    // bready stays low for hold cycles and awready must stay low with it
    task automatic release_b(input int hold);
        repeat (hold) begin
            tick();
            check_value("bvalid held", 1, axi_bvalid);
            check_value("awready under back-pressure", 0, axi_awready);
        end
        axi_bready = 1'b1;
        tick();
        axi_bready = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] idx, input logic [31:0] data,
                             input logic [3:0] strb);
        write_start(idx, data, strb);
        wait_write_ready();
        wait_bvalid();
        release_b({next_rand()} % 4);
        apply_write(idx, data, strb);
    endtask

    task automatic read_check(input logic [3:0] idx);
        logic [31:0] first_data;
        int          waited;
        int          hold;
        hold            = {next_rand()} % 4;
        axi_araddr      = '0;
        axi_araddr[5:2] = idx;
        axi_arvalid     = 1'b1;
        waited          = 0;
        do begin
            tick();
            waited++;
            if (waited > timeout_cycles) begin
                abort_run("timeout: read address was never accepted");
            end
        end while (!axi_arready);
        axi_arvalid = 1'b0;
        waited      = 0;
        while (!axi_rvalid) begin
            tick();
            waited++;
            if (waited > timeout_cycles) begin
                abort_run("timeout: read data never became valid");
            end
        end
        check_value("rresp", wavegen_axi_pkg::resp_okay, axi_rresp);
        check_value($sformatf("read index %0d", idx), shadow[idx], axi_rdata);
        first_data = axi_rdata;
        // data stays frozen while rready is low
        repeat (hold) begin
            tick();
            check_value("rvalid held", 1, axi_rvalid);
            check_value("rdata held", first_data, axi_rdata);
        end
        axi_rready = 1'b1;
        tick();
        axi_rready = 1'b0;
    endtask

    task automatic check_outputs();
        check_value("mode_a", shadow[0][2:0], mode_a);
        check_value("mode_b", shadow[0][5:3], mode_b);
        check_value("enable_a", shadow[1][0], enable_a);
        check_value("enable_b", shadow[1][1], enable_b);
        check_value("freq_a", shadow[2], freq_a);
        check_value("freq_b", shadow[3], freq_b);
        check_value("dtcyc_a", shadow[6][15:0], dtcyc_a);
        check_value("dtcyc_b", shadow[6][31:16], dtcyc_b);
        check_value("cycles_a", shadow[7][15:0], cycles_a);
        check_value("cycles_b", shadow[7][31:16], cycles_b);
        check_value("phase_off_a", shadow[8][15:0], phase_off_a);
        check_value("phase_off_b", shadow[8][31:16], phase_off_b);
        check_value("arb_depth", shadow[9], arb_depth);
        check_value("out_a", expected_scaled(shadow[5][15:0], shadow[4][15:0], wave_a,
                                             shadow[1][0]), out_a);
        check_value("out_b", expected_scaled(shadow[5][31:16], shadow[4][31:16], wave_b,
                                             shadow[1][1]), out_b);
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        int          waited;
        logic [31:0] rnd;
        logic [31:0] data1;
        logic [31:0] data2;
        logic [3:0]  strb2;
        logic [3:0]  idx2;
        seed        = 32'h6b38_6743;
        axi_awaddr  = '0;
        axi_awvalid = 1'b0;
        axi_wdata   = '0;
        axi_wstrb   = '0;
        axi_wvalid  = 1'b0;
        axi_bready  = 1'b0;
        axi_araddr  = '0;
        axi_arvalid = 1'b0;
        axi_rready  = 1'b0;
        wave_a      = '0;
        wave_b      = '0;
        // all zero except run with both channels enabled
        for (int i = 0; i < 16; i++) begin
            shadow[i] = '0;
        end
        shadow[wavegen_reg_pkg::run_reg] = 32'd3;

        waited = 0;
        while (axi_resetn !== 1'b1) begin
            tick();
            waited++;
            if (waited > timeout_cycles) begin
                abort_run("timeout: reset was never released");
            end
        end
        tick();
        check_value("awready after reset", 0, axi_awready);
        check_value("bvalid after reset", 0, axi_bvalid);
        check_value("arready after reset", 0, axi_arready);
        check_value("rvalid after reset", 0, axi_rvalid);

        // reset values of the register map
        for (int i = 0; i < 10; i++) begin
            read_check(i[3:0]);
        end
        check_outputs();

        // random writes over the whole index range with a read after each
        wave_a = next_rand();
        wave_b = next_rand();
        for (int n = 0; n < num_writes; n++) begin
            rnd = next_rand();
            write_reg(rnd[3:0], next_rand(), rnd[4] ? 4'hf : rnd[11:8]);
            check_outputs();
            rnd = next_rand();
            read_check(rnd[3:0]);
        end

        // scaling with both channels on
        write_reg(wavegen_reg_pkg::run_reg, 32'd3, 4'hf);
        for (int n = 0; n < 40; n++) begin
            write_reg(wavegen_reg_pkg::ampltd_reg, next_rand(), 4'hf);
            write_reg(wavegen_reg_pkg::offset_reg, next_rand(), 4'hf);
            wave_a = next_rand();
            wave_b = next_rand();
            tick();
            tick();
            check_outputs();
        end

        // enable gating through run
        for (int n = 0; n < 20; n++) begin
            rnd = next_rand();
            write_reg(wavegen_reg_pkg::run_reg, {30'd0, rnd[1:0]}, 4'h1);
            wave_a = next_rand();
            wave_b = next_rand();
            tick();
            tick();
            if (!rnd[0]) begin
                check_value("out_a gated", 0, out_a);
            end
            if (!rnd[1]) begin
                check_value("out_b gated", 0, out_b);
            end
            check_outputs();
        end

        // second write presented while the first response is stalled
        for (int n = 0; n < 10; n++) begin
            rnd   = next_rand();
            data1 = next_rand();
            write_start(rnd[3:0], data1, 4'hf);
            wait_write_ready();
            wait_bvalid();
            idx2  = next_rand() % 10;
            data2 = next_rand();
            strb2 = next_rand();
            write_start(idx2, data2, strb2);
            release_b(2 + {next_rand()} % 8);
            apply_write(rnd[3:0], data1, 4'hf);
            wait_write_ready();
            wait_bvalid();
            release_b({next_rand()} % 4);
            apply_write(idx2, data2, strb2);
            check_outputs();
            read_check(idx2);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- wavegen_top.f
rtl/wavegen_axi_pkg.sv
rtl/wavegen_reg_pkg.sv
rtl/wavegen_axi_write.sv
rtl/wavegen_axi_read.sv
rtl/wavegen_regs.sv
rtl/wavegen_scale.sv
rtl/wavegen_top.sv
sim/wavegen_clk_gen.sv
sim/wavegen_tb.sv
